// ==== board_mem_top.f ====
source/mem_map_pkg.sv
source/phy_mem_ctrl.sv
source/uart_tx.sv
source/uart_rx.sv
source/seg7_display.sv
source/board_mem_top.sv
verification/board_mem_models.sv
verification/tb_board_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the board memory testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_board_mem -f board_mem_top.f \
	--Mdir "$build_dir" -o tb_board_mem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./"$build_dir"/tb_board_mem > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$log"; then
	exit 1
fi
exit 0

// ==== verification/tb_board_mem.sv ====
module tb_board_mem;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_map_pkg::*;

	localparam int clks_per_bit = 16;
	localparam int scan_div = 4;
	localparam int ram_write_width = 1;
	localparam int ram_recovery = 1;
	localparam int flash_write_width = 4;
	localparam int flash_recovery = 2;

	// cycles from the write clock until busy is seen low
	localparam word_t ram_busy = ram_write_width + ram_recovery + 1;
	localparam word_t flash_busy = flash_write_width + flash_recovery + 1;
	localparam word_t imm_busy = 1;

	// gfedcba, active high
	localparam logic [6:0] seg_lut [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	typedef logic [8*16-1:0] name_t;
	typedef enum logic [2:0] {op_write, op_read, op_ser_send, op_ser_expect, op_display} op_e;
	typedef struct packed {
		op_e op;
		word_t addr;
		word_t data;
		word_t exp;	// busy cycles for writes, byte for serial send
		name_t name;
	} entry_t;

	logic clk50M, rst, is_write, busy, rxd, txd;
	word_t addr, data_in, data_out;
	sram_addr_t baseram_addr, extram_addr;
	word_t baseram_wdata, baseram_rdata, extram_wdata, extram_rdata;
	logic baseram_ce, baseram_oe, baseram_we, baseram_drive;
	logic extram_ce, extram_oe, extram_we, extram_drive;
	flash_addr_t flash_addr;
	flash_word_t flash_wdata, flash_rdata;
	logic flash_drive;
	flash_ctl_t flash_ctl;
	logic [7:0] seg_digit_n;
	logic [6:0] seg_segments_n;

	entry_t tests[$];
	bit table_ready = 1'b0;
	int seed = 62;
	int checks = 0;
	int errors = 0;

	board_mem_top #(
		.clks_per_bit(clks_per_bit),
		.scan_div(scan_div),
		.ram_write_width(ram_write_width),
		.ram_recovery(ram_recovery),
		.flash_write_width(flash_write_width),
		.flash_recovery(flash_recovery)
	) u_dut (.*);

	sram_model u_baseram (.addr(baseram_addr), .wdata(baseram_wdata), .rdata(baseram_rdata),
		.ce_n(baseram_ce), .oe_n(baseram_oe), .we_n(baseram_we), .drive(baseram_drive));
	sram_model u_extram (.addr(extram_addr), .wdata(extram_wdata), .rdata(extram_rdata),
		.ce_n(extram_ce), .oe_n(extram_oe), .we_n(extram_we), .drive(extram_drive));
	flash_model u_flash (.addr(flash_addr), .wdata(flash_wdata), .rdata(flash_rdata),
		.ctl(flash_ctl), .drive(flash_drive));

	initial begin
		clk50M = 1'b0;
		forever #4 clk50M = ~clk50M;
	end

	task automatic add_test(input op_e op, input word_t a, input word_t d, input word_t e,
		input name_t n);
		tests.push_back('{op, a, d, e, n});
	endtask

	task automatic report_mismatch(input name_t name, input word_t exp, input word_t act);
		errors++;
		$display("[ERROR] %0s: expected %h, got %h", name, exp, act);
	endtask

	task automatic build_table();
		word_t r0, r1, r2, r3;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		add_test(op_read, com_stat_addr, '0, 32'h1, "stat reset");
		add_test(op_read, segdisp_addr, '0, '0, "disp reset");
		add_test(op_write, 32'h0000_0100, r0, ram_busy, "base write");
		add_test(op_write, 32'h0040_0100, r1, ram_busy, "ext write");	// same word, other bank
		add_test(op_read, 32'h0000_0100, '0, r0, "base read");
		add_test(op_read, 32'h0040_0100, '0, r1, "ext read");
		add_test(op_read, 32'h8000_0000, '0, '0, "unmapped read");
		add_test(op_write, 32'h1E00_0040, r2, flash_busy, "flash write a");
		add_test(op_write, 32'h1E12_3454, r3, flash_busy, "flash write b");
		add_test(op_read, 32'h1E00_0040, '0, {16'b0, r2[15:0]}, "flash read a");
		add_test(op_read, 32'h1E12_3454, '0, {16'b0, r3[15:0]}, "flash read b");
		add_test(op_ser_send, com_data_addr, 32'h0000_0125, 32'h25, "serial send");
		add_test(op_read, com_stat_addr, '0, 32'h1, "stat tx done");
		add_test(op_ser_expect, com_data_addr, 32'h3C, '0, "serial recv");
		add_test(op_read, com_stat_addr, '0, 32'h3, "stat rx ready");
		add_test(op_read, com_data_addr, '0, 32'h3C, "rx data read");
		add_test(op_read, com_stat_addr, '0, 32'h1, "stat rx acked");
		add_test(op_display, segdisp_addr, 32'h7A4F_0C93, '0, "display");
		add_test(op_read, segdisp_addr, '0, 32'h7A4F_0C93, "disp readback");
	endtask

	// entered and left on a falling edge
	task automatic host_write(input word_t a, input word_t d, input word_t exp_cycles,
		input name_t name);
		int n;
		n = 0;
		addr = a;
		data_in = d;
		is_write = 1'b1;
		@(negedge clk50M);
		is_write = 1'b0;
		do begin
			@(negedge clk50M);
			n++;
		end while (busy && n < 64);
		checks++;
		if (word_t'(n) !== exp_cycles)
			report_mismatch(name, exp_cycles, word_t'(n));
	endtask

	task automatic check_read(input word_t a, input word_t exp, input name_t name);
		addr = a;
		@(negedge clk50M);
		checks++;
		if (data_out !== exp)
			report_mismatch(name, exp, data_out);
		if ((baseram_drive | extram_drive | flash_drive) !== 1'b0) begin	// bus released on reads
			errors++;
			$display("%0s: data bus still driven during a read", name);
		end
	endtask

	// poll the status register like software would
	task automatic wait_status(input int idx, input name_t name);
		int n;
		n = 0;
		addr = com_stat_addr;
		@(negedge clk50M);
		while (!data_out[idx] && n < 20 * clks_per_bit) begin
			@(negedge clk50M);
			n++;
		end
		checks++;
		if (!data_out[idx]) begin
			errors++;
			$display("%0s: status bit %0d never went high", name, idx);
		end
	endtask

	task automatic decode_frame(output byte_t b, input name_t name);
		int n;
		int i;
		n = 0;
		b = '0;
		while (txd && n < 4 * clks_per_bit) begin
			@(negedge clk50M);
			n++;
		end
		checks++;
		if (txd) begin
			errors++;
			$display("%0s: no start bit appeared on txd", name);
		end else begin
			repeat (clks_per_bit / 2) @(negedge clk50M);	// middle of start bit
			if (txd) begin
				errors++;
				$display("%0s: start bit on txd too short", name);
			end
			for (i = 0; i < 8; i++) begin
				repeat (clks_per_bit) @(negedge clk50M);
				b[i] = txd;	// lsb first
			end
			repeat (clks_per_bit) @(negedge clk50M);
			if (!txd) begin
				errors++;
				$display("%0s: stop bit on txd was low", name);
			end
		end
	endtask

	task automatic send_frame(input byte_t b);
		int i;
		rxd = 1'b0;
		repeat (clks_per_bit) @(negedge clk50M);
		for (i = 0; i < 8; i++) begin
			rxd = b[i];
			repeat (clks_per_bit) @(negedge clk50M);
		end
		rxd = 1'b1;
		repeat (clks_per_bit) @(negedge clk50M);
	endtask

	task automatic check_digits(input word_t val, input name_t name);
		int k;
		int n;
		logic [6:0] want;
		for (k = 0; k < 8; k++) begin
			n = 0;
			while (seg_digit_n !== ~(8'b1 << k) && n < 16 * scan_div) begin
				@(negedge clk50M);
				n++;
			end
			want = ~seg_lut[val[k*4 +: 4]];
			checks++;
			if (seg_digit_n !== ~(8'b1 << k)) begin
				errors++;
				$display("%0s: digit %0d was never selected", name, k);
			end else if (seg_segments_n !== want)
				report_mismatch(name, {25'b0, want}, {25'b0, seg_segments_n});
		end
	endtask

	initial begin
		entry_t e;
		byte_t got;
		rst = 1'b1;
		is_write = 1'b0;
		addr = '0;
		data_in = '0;
		rxd = 1'b1;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk50M);
		@(negedge clk50M);
		rst = 1'b0;
		foreach (tests[i]) begin
			e = tests[i];
			case (e.op)
				op_write: host_write(e.addr, e.data, e.exp, e.name);
				op_read: check_read(e.addr, e.exp, e.name);
				op_ser_send: begin
					host_write(e.addr, e.data, imm_busy, e.name);
					check_read(com_stat_addr, 32'h0, e.name);	// frame in progress
					decode_frame(got, e.name);
					if (got !== e.exp[7:0])
						report_mismatch(e.name, e.exp, {24'b0, got});
					wait_status(0, e.name);
				end
				op_ser_expect: begin
					send_frame(e.data[7:0]);
					wait_status(1, e.name);
				end
				op_display: begin
					host_write(e.addr, e.data, imm_busy, e.name);
					check_digits(e.data, e.name);
				end
				default: ;
			endcase
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog, 20 serial frames per table entry
	initial begin
		longint limit;
		wait (table_ready);
		limit = longint'(tests.size()) * 20 * 10 * clks_per_bit * 8;
		#(limit);
		$display("timeout: tests still running after %0d ns", limit);
		$display("checks: %0d, errors: %0d", checks, errors + 1);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== verification/board_mem_models.sv ====
module sram_model (
	input mem_map_pkg::sram_addr_t addr,
	input mem_map_pkg::word_t wdata,
	output mem_map_pkg::word_t rdata,
	input logic ce_n,
	input logic oe_n,
	input logic we_n,
	input logic drive
);
	timeunit 1ns;
	timeprecision 100ps;
	import mem_map_pkg::*;

	word_t mem [sram_addr_t];	// sparse, unwritten words read as zero

	// word is taken when we rises
	always @(posedge we_n) begin
		if (drive && !ce_n)
			mem[addr] = wdata;
	end

	always_comb begin
		if (!ce_n && !oe_n && mem.exists(addr))
			rdata = mem[addr];
		else
			rdata = '0;
	end

endmodule

module flash_model (
	input mem_map_pkg::flash_addr_t addr,
	input mem_map_pkg::flash_word_t wdata,
	output mem_map_pkg::flash_word_t rdata,
	input mem_map_pkg::flash_ctl_t ctl,
	input logic drive
);
	timeunit 1ns;
	timeprecision 100ps;
	import mem_map_pkg::*;

	flash_word_t mem [flash_addr_t];

	// raw bus write, no command decoding
	always @(posedge ctl.we) begin
		if (drive && !ctl.ce)
			mem[addr] = wdata;
	end

	always_comb begin
		if (!ctl.ce && !ctl.oe && mem.exists(addr))
			rdata = mem[addr];
		else
			rdata = '0;
	end

endmodule

// ==== source/board_mem_top.sv ====
module board_mem_top #(
	parameter int clks_per_bit = 434,	// 115200 baud at 50 MHz
	parameter int scan_div = 50000,
	parameter int ram_write_width = 1,
	parameter int ram_recovery = 1,
	parameter int flash_write_width = 4,
	parameter int flash_recovery = 2
) (
	input logic clk50M,
	input logic rst,

	input logic is_write,
	input mem_map_pkg::word_t addr,
	input mem_map_pkg::word_t data_in,
	output mem_map_pkg::word_t data_out,
	output logic busy,

	output mem_map_pkg::sram_addr_t baseram_addr,
	output mem_map_pkg::word_t baseram_wdata,
	input mem_map_pkg::word_t baseram_rdata,
	output logic baseram_ce,
	output logic baseram_oe,
	output logic baseram_we,
	output logic baseram_drive,
	output mem_map_pkg::sram_addr_t extram_addr,
	output mem_map_pkg::word_t extram_wdata,
	input mem_map_pkg::word_t extram_rdata,
	output logic extram_ce,
	output logic extram_oe,
	output logic extram_we,
	output logic extram_drive,

	output mem_map_pkg::flash_addr_t flash_addr,
	output mem_map_pkg::flash_word_t flash_wdata,
	input mem_map_pkg::flash_word_t flash_rdata,
	output logic flash_drive,
	output mem_map_pkg::flash_ctl_t flash_ctl,

	input logic rxd,
	output logic txd,

	output logic [7:0] seg_digit_n,
	output logic [6:0] seg_segments_n
);
	import mem_map_pkg::*;

	// links between controller and peripherals
	byte_t com_tx_data;
	logic com_tx_start;
	logic write_ready;
	byte_t com_rx_data;
	logic read_ready;
	logic com_rx_ack;
	word_t segdisp;

	phy_mem_ctrl #(
		.ram_write_width(ram_write_width),
		.ram_recovery(ram_recovery),
		.flash_write_width(flash_write_width),
		.flash_recovery(flash_recovery)
	) u_phy_mem_ctrl (.*);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (.*);

	uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (.*);

	seg7_display #(.scan_div(scan_div)) u_seg7_display (.*);

endmodule

// ==== source/seg7_display.sv ====
module seg7_display #(
	parameter int scan_div = 50000
) (
	input logic clk50M,
	input logic rst,
	input mem_map_pkg::word_t segdisp,
	output logic [7:0] seg_digit_n,
	output logic [6:0] seg_segments_n
);
	localparam int div_w = $clog2(scan_div + 1);

	logic [div_w-1:0] div_cnt;
	logic [2:0] digit;
	logic [3:0] nibble;

	always_ff @(posedge clk50M) begin
		if (rst) begin
			div_cnt <= '0;
			digit <= '0;
		end else if (div_cnt == div_w'(scan_div - 1)) begin
			div_cnt <= '0;
			digit <= digit + 1'b1;	// wraps after digit 7
		end else
			div_cnt <= div_cnt + 1'b1;
	end

	assign seg_digit_n = ~(8'b1 << digit);
	assign nibble = segdisp[digit*4 +: 4];

	// segments gfedcba, active low
	always_comb begin
		case (nibble)
			4'h0: seg_segments_n = ~7'h3F;
			4'h1: seg_segments_n = ~7'h06;
			4'h2: seg_segments_n = ~7'h5B;
			4'h3: seg_segments_n = ~7'h4F;
			4'h4: seg_segments_n = ~7'h66;
			4'h5: seg_segments_n = ~7'h6D;
			4'h6: seg_segments_n = ~7'h7D;
			4'h7: seg_segments_n = ~7'h07;
			4'h8: seg_segments_n = ~7'h7F;
			4'h9: seg_segments_n = ~7'h6F;
			4'hA: seg_segments_n = ~7'h77;
			4'hB: seg_segments_n = ~7'h7C;
			4'hC: seg_segments_n = ~7'h39;
			4'hD: seg_segments_n = ~7'h5E;
			4'hE: seg_segments_n = ~7'h79;
			default: seg_segments_n = ~7'h71;
		endcase
	end

	a_one_digit: assert property (@(posedge clk50M) disable iff (rst) $onehot(~seg_digit_n))
		else $error("digit select not one-hot: %b", seg_digit_n);

endmodule

// ==== source/uart_rx.sv ====
module uart_rx #(
	parameter int clks_per_bit = 434
) (
	input logic clk50M,
	input logic rst,
	input logic rxd,
	input logic com_rx_ack,
	output mem_map_pkg::byte_t com_rx_data,
	output logic read_ready
);
	import mem_map_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit + 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_e;

	rx_state_e state;
	logic rxd_meta;
	logic rxd_sync;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic half_end;
	logic bit_end;
	byte_t shift;

	assign half_end = (clk_cnt == cnt_w'(clks_per_bit / 2 - 1));
	assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge clk50M) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			state <= rx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			read_ready <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			clk_cnt <= clk_cnt + 1'b1;
			if (com_rx_ack)
				read_ready <= 1'b0;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					if (!rxd_sync)
						state <= rx_start;
				end
				// recheck at middle of start bit, from here on sample mid-bit
				rx_start: if (half_end) begin
					clk_cnt <= '0;
					bit_idx <= '0;
					state <= rxd_sync ? rx_idle : rx_data;
				end
				rx_data: if (bit_end) begin
					clk_cnt <= '0;
					shift <= {rxd_sync, shift[7:1]};
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= rx_stop;
				end
				rx_stop: if (bit_end) begin
					state <= rx_idle;
					if (rxd_sync) begin	// bad stop bit drops the frame
						com_rx_data <= shift;
						read_ready <= 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

// ==== source/uart_tx.sv ====
module uart_tx #(
	parameter int clks_per_bit = 434
) (
	input logic clk50M,
	input logic rst,
	input mem_map_pkg::byte_t com_tx_data,
	input logic com_tx_start,
	output logic write_ready,
	output logic txd
);
	import mem_map_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit + 1);

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_e;

	tx_state_e state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic bit_end;
	byte_t shift;

	assign bit_end = (clk_cnt == cnt_w'(clks_per_bit - 1));
	assign write_ready = (state == tx_idle);

	always_ff @(posedge clk50M) begin
		if (rst) begin
			state <= tx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd <= 1'b1;	// line idles high
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				tx_idle: begin
					clk_cnt <= '0;
					if (com_tx_start) begin
						shift <= com_tx_data;
						txd <= 1'b0;
						state <= tx_start;
					end
				end
				tx_start: if (bit_end) begin
					txd <= shift[0];	// lsb first
					bit_idx <= '0;
					state <= tx_data;
				end
				tx_data: if (bit_end) begin
					shift <= {1'b0, shift[7:1]};
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						txd <= 1'b1;
						state <= tx_stop;
					end else
						txd <= shift[1];
				end
				tx_stop: if (bit_end)
					state <= tx_idle;
				default: state <= tx_idle;
			endcase
		end
	end

	a_start_when_ready: assert property (@(posedge clk50M) disable iff (rst)
		com_tx_start |-> write_ready)
		else $error("serial write dropped, transmitter busy");

endmodule

// ==== source/phy_mem_ctrl.sv ====
module phy_mem_ctrl #(
	parameter int ram_write_width = 1,
	parameter int ram_recovery = 1,
	parameter int flash_write_width = 4,
	parameter int flash_recovery = 2
) (
	input logic clk50M,
	input logic rst,

	input logic is_write,
	input mem_map_pkg::word_t addr,
	input mem_map_pkg::word_t data_in,
	output mem_map_pkg::word_t data_out,
	output logic busy,

	output mem_map_pkg::sram_addr_t baseram_addr,
	output mem_map_pkg::word_t baseram_wdata,
	input mem_map_pkg::word_t baseram_rdata,
	output logic baseram_ce,
	output logic baseram_oe,
	output logic baseram_we,
	output logic baseram_drive,
	output mem_map_pkg::sram_addr_t extram_addr,
	output mem_map_pkg::word_t extram_wdata,
	input mem_map_pkg::word_t extram_rdata,
	output logic extram_ce,
	output logic extram_oe,
	output logic extram_we,
	output logic extram_drive,

	output mem_map_pkg::flash_addr_t flash_addr,
	output mem_map_pkg::flash_word_t flash_wdata,
	input mem_map_pkg::flash_word_t flash_rdata,
	output logic flash_drive,
	output mem_map_pkg::flash_ctl_t flash_ctl,

	output mem_map_pkg::byte_t com_tx_data,
	output logic com_tx_start,
	input logic write_ready,
	input mem_map_pkg::byte_t com_rx_data,
	input logic read_ready,
	output logic com_rx_ack,

	output mem_map_pkg::word_t segdisp
);
	import mem_map_pkg::*;

	localparam int ram_span = ram_write_width + ram_recovery;
	localparam int flash_span = flash_write_width + flash_recovery;
	localparam int max_span = (ram_span > flash_span) ? ram_span : flash_span;
	localparam int cnt_w = $clog2(max_span + 1);

	region_e region;
	wr_state_e state;
	logic [cnt_w-1:0] write_cnt;
	logic [cnt_w-1:0] write_cnt_next;
	logic is_write_prev;
	logic is_write_posedge;
	word_t wr_addr_q;
	word_t wr_data_q;
	logic com_data_rd;
	logic com_data_rd_prev;
	logic ram_rd;
	logic ram_wr;
	logic ram_sel;
	logic ram_we_act;
	sram_addr_t ram_addr;
	logic flash_rd;
	logic flash_wr;

	always_comb begin
		if ((addr & ~ram_span_mask) == '0)
			region = region_ram;
		else if (addr[31:24] == flash_page)
			region = region_flash;
		else if (addr == com_data_addr)
			region = region_com_data;
		else if (addr == com_stat_addr)
			region = region_com_stat;
		else if (addr == segdisp_addr)
			region = region_segdisp;
		else
			region = region_none;
	end

	assign is_write_posedge = is_write && !is_write_prev;
	assign busy = is_write || (state != st_idle);
	assign write_cnt_next = write_cnt + 1'b1;

	// serial send goes straight to the transmitter
	assign com_tx_start = is_write_posedge && (state == st_idle) && (region == region_com_data);
	assign com_tx_data = data_in[7:0];

	// ack only on the first cycle of a data register read
	assign com_data_rd = (region == region_com_data) && !is_write && (state == st_idle);
	assign com_rx_ack = com_data_rd && !com_data_rd_prev;

	always_ff @(posedge clk50M) begin
		if (rst) begin
			state <= st_idle;
			write_cnt <= '0;
			is_write_prev <= 1'b0;
			com_data_rd_prev <= 1'b0;
			segdisp <= '0;
		end else begin
			is_write_prev <= is_write;
			com_data_rd_prev <= com_data_rd;
			case (state)
				st_idle: if (is_write_posedge) begin
					write_cnt <= '0;
					case (region)
						region_ram: state <= st_write_ram;
						region_flash: state <= st_write_flash;
						region_segdisp: segdisp <= data_in;
						default: ;	// serial or unmapped, nothing to sequence
					endcase
				end
				st_write_ram: begin
					write_cnt <= write_cnt_next;
					if (write_cnt_next == cnt_w'(ram_span))
						state <= st_recover;
				end
				st_write_flash: begin
					write_cnt <= write_cnt_next;
					if (write_cnt_next == cnt_w'(flash_span))
						state <= st_recover;
				end
				st_recover: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk50M) begin
		if (state == st_idle && is_write_posedge) begin
			wr_addr_q <= addr;
			wr_data_q <= data_in;
		end
	end

	// sram banks, bit 22 picks the bank
	assign ram_wr = (state == st_write_ram);
	assign ram_rd = (state == st_idle) && (region == region_ram);
	assign ram_sel = ram_wr ? wr_addr_q[22] : addr[22];
	assign ram_addr = ram_wr ? wr_addr_q[21:2] : addr[21:2];
	assign ram_we_act = ram_wr && (write_cnt < cnt_w'(ram_write_width));

	assign baseram_addr = ram_addr;
	assign extram_addr = ram_addr;
	assign baseram_wdata = wr_data_q;
	assign extram_wdata = wr_data_q;
	assign baseram_ce = !((ram_rd || ram_wr) && !ram_sel);
	assign extram_ce = !((ram_rd || ram_wr) && ram_sel);
	assign baseram_oe = !(ram_rd && !ram_sel);
	assign extram_oe = !(ram_rd && ram_sel);
	assign baseram_we = !(ram_we_act && !ram_sel);
	assign extram_we = !(ram_we_act && ram_sel);
	// data held across the rising we edge
	assign baseram_drive = ram_wr && !ram_sel;
	assign extram_drive = ram_wr && ram_sel;

	assign flash_wr = (state == st_write_flash);
	assign flash_rd = (state == st_idle) && (region == region_flash);
	assign flash_addr = flash_wr ? wr_addr_q[23:1] : addr[23:1];
	assign flash_wdata = wr_data_q[15:0];
	assign flash_drive = flash_wr;

	always_comb begin
		flash_ctl.byte_n = 1'b1;	// 16-bit mode
		flash_ctl.ce = !(flash_rd || flash_wr);
		flash_ctl.ce1 = 1'b0;
		flash_ctl.ce2 = 1'b0;
		flash_ctl.oe = !flash_rd;
		flash_ctl.rp = 1'b1;
		flash_ctl.vpen = 1'b1;
		flash_ctl.we = !(flash_wr && (write_cnt < cnt_w'(flash_write_width)));
	end

	always_comb begin
		case (region)
			region_ram: data_out = ram_sel ? extram_rdata : baseram_rdata;
			region_flash: data_out = {16'b0, flash_rdata};
			region_com_data: data_out = {24'b0, com_rx_data};
			region_com_stat: data_out = {30'b0, read_ready, write_ready};
			region_segdisp: data_out = segdisp;
			default: data_out = '0;
		endcase
	end

	a_aligned: assert property (@(posedge clk50M) disable iff (rst) addr[1:0] == 2'b00)
		else $error("unaligned access to %h", addr);

	// host must wait for busy low before the next write
	a_write_when_idle: assert property (@(posedge clk50M) disable iff (rst)
		is_write_posedge |-> state == st_idle)
		else $error("write pulse while sequencer busy");

	a_one_bank: assert property (@(posedge clk50M) disable iff (rst)
		!(!baseram_ce && !extram_ce))
		else $error("both sram banks enabled");

endmodule

// ==== source/mem_map_pkg.sv ====
package mem_map_pkg;

	// bus and pin widths
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [19:0] sram_addr_t;	// word address inside one bank
	typedef logic [22:0] flash_addr_t;	// halfword address
	typedef logic [15:0] flash_word_t;

	// i/o registers
	localparam word_t com_data_addr = 32'h1FD003F8;	// low byte only
	localparam word_t com_stat_addr = 32'h1FD003FC;	// {30'b0, read_ready, write_ready}
	localparam word_t segdisp_addr = 32'h1FD00400;

	// ram window is 8 MiB starting at zero
	localparam word_t ram_span_mask = 32'h007FFFFF;
	localparam logic [7:0] flash_page = 8'h1E;	// top address byte of flash

	typedef enum logic [2:0] {
		region_ram,
		region_flash,
		region_com_data,
		region_com_stat,
		region_segdisp,
		region_none
	} region_e;

	typedef enum logic [1:0] {
		st_idle,
		st_write_ram,
		st_write_flash,
		st_recover
	} wr_state_e;

	// flash control pins, msb first as on the board header
	typedef struct packed {
		logic byte_n;
		logic ce;
		logic ce1;
		logic ce2;
		logic oe;
		logic rp;
		logic vpen;
		logic we;
	} flash_ctl_t;

endpackage
